/* source/tracker_defines.svh */
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// screen coordinate widths
`define H_W 11 // horizontal count
`define V_W 10 // vertical count

`define COLOR_W 8 // one color channel

// pipeline depths, in clk_pixel cycles
`define CONV_LATENCY 3 // rgb in to ycrcb out
`define MASK_LATENCY 4 // pixel in to mask bits out

// fixed cb window for the saber target
`define SABER_CB_LO 8'h0E
`define SABER_CB_HI 8'h20

`define COUNT_W 20 // masked pixel count per frame
`define SUM_W 32 // coordinate sums, also divider step count

`endif

/* source/video_pkg.sv */
`include "tracker_defines.svh"

package video_pkg;

  // 5-6-5 packed pixel, red in the top bits
  typedef logic [15:0] rgb565_t;

  // one expanded channel value
  typedef logic [`COLOR_W-1:0] color_t;

  // which channel the player threshold looks at
  // 3 and 7 are unused codes
  typedef enum logic [2:0] {
    CH_GREEN = 3'd0,
    CH_RED = 3'd1,
    CH_BLUE = 3'd2,
    CH_Y = 3'd4, // luma
    CH_CR = 3'd5, // red chroma
    CH_CB = 3'd6 // blue chroma
  } channel_sel_e;

endpackage

/* source/track_pkg.sv */
`include "tracker_defines.svh"

package track_pkg;

  typedef logic [`H_W-1:0] hcount_t; // x position
  typedef logic [`V_W-1:0] vcount_t; // y position

  typedef logic [`COUNT_W-1:0] count_t; // pixels per frame
  typedef logic [`SUM_W-1:0] sum_t; // running coordinate sum

  // center of mass divider sequencing
  typedef enum logic [1:0] {
    COM_IDLE,
    COM_DIVIDE,
    COM_DONE
  } com_state_e;

endpackage

/* source/color_convert.sv */
`timescale 1ns/10ps
`include "tracker_defines.svh"

module color_convert import video_pkg::*; (
  input logic clk_pixel,
  input logic sys_rst,
  input rgb565_t pixel,
  input logic pixel_valid,
  output color_t red,
  output color_t green,
  output color_t blue,
  output color_t y,
  output color_t cr,
  output color_t cb,
  output logic conv_valid
);

  color_t r_exp, g_exp, b_exp; // 8-bit channels from 5-6-5
  logic signed [17:0] r_s, g_s, b_s; // zero-extended for signed math

  // stage 1 products, all kept positive
  logic signed [17:0] yr_p, yg_p, yb_p;
  logic signed [17:0] cbr_p, cbg_p, cbb_p;
  logic signed [17:0] crr_p, crg_p, crb_p;

  // stage 2 rounded sums
  logic signed [17:0] y_sum, cb_sum, cr_sum;

  // rgb and valid ride alongside the math
  color_t red_pipe [`CONV_LATENCY];
  color_t green_pipe [`CONV_LATENCY];
  color_t blue_pipe [`CONV_LATENCY];
  logic [`CONV_LATENCY-1:0] valid_pipe;

  assign r_exp = {pixel[15:11], 3'b000};
  assign g_exp = {pixel[10:5], 2'b00};
  assign b_exp = {pixel[4:0], 3'b000};

  assign r_s = {10'b0, r_exp};
  assign g_s = {10'b0, g_exp};
  assign b_s = {10'b0, b_exp};

  always_ff @(posedge clk_pixel) begin
    yr_p <= r_s * 18'sd66; // luma weights
    yg_p <= g_s * 18'sd129;
    yb_p <= b_s * 18'sd25;
    cbr_p <= r_s * 18'sd38; // subtracted in stage 2
    cbg_p <= g_s * 18'sd74;
    cbb_p <= b_s * 18'sd112;
    crr_p <= r_s * 18'sd112;
    crg_p <= g_s * 18'sd94;
    crb_p <= b_s * 18'sd18;
    // +128 rounds before the shift
    y_sum <= yr_p + yg_p + yb_p + 18'sd128;
    cb_sum <= cbb_p - cbr_p - cbg_p + 18'sd128;
    cr_sum <= crr_p - crg_p - crb_p + 18'sd128;
    // arithmetic shift, offset, keep low byte
    y <= color_t'((y_sum >>> 8) + 18'sd16);
    cb <= color_t'((cb_sum >>> 8) + 18'sd128);
    cr <= color_t'((cr_sum >>> 8) + 18'sd128);
  end

  always_ff @(posedge clk_pixel) begin
    red_pipe[0] <= r_exp;
    green_pipe[0] <= g_exp;
    blue_pipe[0] <= b_exp;
    for (int i = 1; i < `CONV_LATENCY; i++) begin
      red_pipe[i] <= red_pipe[i-1];
      green_pipe[i] <= green_pipe[i-1];
      blue_pipe[i] <= blue_pipe[i-1];
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      valid_pipe <= '0;
    end else begin
      valid_pipe <= {valid_pipe[`CONV_LATENCY-2:0], pixel_valid};
    end
  end

  assign red = red_pipe[`CONV_LATENCY-1];
  assign green = green_pipe[`CONV_LATENCY-1];
  assign blue = blue_pipe[`CONV_LATENCY-1];
  assign conv_valid = valid_pipe[`CONV_LATENCY-1];

endmodule

/* source/channel_mask.sv */
`timescale 1ns/10ps
`include "tracker_defines.svh"

module channel_mask import video_pkg::*; (
  input logic clk_pixel,
  input logic sys_rst,
  input color_t red,
  input color_t green,
  input color_t blue,
  input color_t y,
  input color_t cr,
  input color_t cb,
  input logic conv_valid,
  input channel_sel_e channel_sel,
  input color_t lower_bound,
  input color_t upper_bound,
  output logic player_mask,
  output logic saber_mask
);

  color_t selected; // channel under the player threshold

  always_comb begin
    case (channel_sel)
      CH_GREEN: selected = green;
      CH_RED: selected = red;
      CH_BLUE: selected = blue;
      CH_Y: selected = y;
      CH_CR: selected = cr;
      CH_CB: selected = cb;
      default: selected = '0; // unused codes read as black
    endcase
  end

  // both windows inclusive at each end
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      player_mask <= 1'b0;
      saber_mask <= 1'b0;
    end else begin
      player_mask <= conv_valid &&
                     (selected >= lower_bound) && (selected <= upper_bound);
      saber_mask <= conv_valid &&
                    (cb >= `SABER_CB_LO) && (cb <= `SABER_CB_HI); // fixed blue window
    end
  end

endmodule

/* source/bounding_box.sv */
`timescale 1ns/10ps

module bounding_box import track_pkg::*; (
  input logic clk_pixel,
  input logic sys_rst,
  input hcount_t hcount,
  input vcount_t vcount,
  input logic frame_start,
  input logic player_mask,
  output hcount_t box_x_min,
  output hcount_t box_x_max,
  output vcount_t box_y_min,
  output vcount_t box_y_max,
  output logic box_found,
  output logic box_valid
);

  // running extent of the current frame
  hcount_t x_lo, x_hi;
  vcount_t y_lo, y_hi;
  logic seen; // any masked pixel yet this frame

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      seen <= 1'b0;
      box_valid <= 1'b0;
      box_found <= 1'b0;
      box_x_min <= '0;
      box_x_max <= '0;
      box_y_min <= '0;
      box_y_max <= '0;
    end else begin
      box_valid <= frame_start; // one pulse per strobe
      if (frame_start) begin
        box_found <= seen;
        if (seen) begin // empty frame leaves old box in place
          box_x_min <= x_lo;
          box_x_max <= x_hi;
          box_y_min <= y_lo;
          box_y_max <= y_hi;
        end
        // strobe-cycle pixel opens the next frame
        seen <= player_mask;
        x_lo <= hcount;
        x_hi <= hcount;
        y_lo <= vcount;
        y_hi <= vcount;
      end else if (player_mask) begin
        seen <= 1'b1;
        x_lo <= (!seen || hcount < x_lo) ? hcount : x_lo;
        x_hi <= (!seen || hcount > x_hi) ? hcount : x_hi;
        y_lo <= (!seen || vcount < y_lo) ? vcount : y_lo;
        y_hi <= (!seen || vcount > y_hi) ? vcount : y_hi;
      end
    end
  end

endmodule

/* source/center_of_mass.sv */
`timescale 1ns/10ps
`include "tracker_defines.svh"

module center_of_mass import track_pkg::*; (
  input logic clk_pixel,
  input logic sys_rst,
  input hcount_t hcount,
  input vcount_t vcount,
  input logic frame_start,
  input logic saber_mask,
  output hcount_t com_x,
  output vcount_t com_y,
  output logic com_valid
);

  sum_t sum_x, sum_y; // live accumulators
  count_t count;

  com_state_e state;
  logic [$clog2(`SUM_W):0] step; // divider bit index

  // dividends shift left, quotient bits fill in from the bottom
  sum_t quot_x, quot_y;
  count_t rem_x, rem_y;
  count_t divisor; // frozen pixel count

  logic [`COUNT_W:0] trial_x, trial_y; // remainder with next dividend bit
  logic fit_x, fit_y;

  assign trial_x = {rem_x, quot_x[`SUM_W-1]};
  assign trial_y = {rem_y, quot_y[`SUM_W-1]};
  assign fit_x = trial_x >= {1'b0, divisor};
  assign fit_y = trial_y >= {1'b0, divisor};

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      sum_x <= '0;
      sum_y <= '0;
      count <= '0;
    end else if (frame_start) begin
      // restart, strobe-cycle pixel counts toward the new frame
      sum_x <= saber_mask ? sum_t'(hcount) : '0;
      sum_y <= saber_mask ? sum_t'(vcount) : '0;
      count <= count_t'(saber_mask);
    end else if (saber_mask) begin
      sum_x <= sum_x + sum_t'(hcount);
      sum_y <= sum_y + sum_t'(vcount);
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      state <= COM_IDLE;
      com_valid <= 1'b0;
      com_x <= '0;
      com_y <= '0;
    end else begin
      com_valid <= 1'b0;
      case (state)
        COM_IDLE: begin
          if (frame_start && count != '0) begin // nothing to divide on an empty frame
            state <= COM_DIVIDE;
          end
        end
        COM_DIVIDE: begin
          if (step == `SUM_W - 1) begin
            state <= COM_DONE;
          end
        end
        COM_DONE: begin
          com_valid <= 1'b1;
          com_x <= hcount_t'(quot_x); // average always fits the screen
          com_y <= vcount_t'(quot_y);
          state <= COM_IDLE;
        end
        default: state <= COM_IDLE;
      endcase
    end
  end

  // restoring divide, one quotient bit per cycle for both axes
  always_ff @(posedge clk_pixel) begin
    if (state == COM_IDLE) begin
      quot_x <= sum_x; // snapshot
      quot_y <= sum_y;
      divisor <= count;
      rem_x <= '0;
      rem_y <= '0;
      step <= '0;
    end else if (state == COM_DIVIDE) begin
      rem_x <= fit_x ? count_t'(trial_x - {1'b0, divisor}) : count_t'(trial_x);
      rem_y <= fit_y ? count_t'(trial_y - {1'b0, divisor}) : count_t'(trial_y);
      quot_x <= {quot_x[`SUM_W-2:0], fit_x};
      quot_y <= {quot_y[`SUM_W-2:0], fit_y};
      step <= step + 1'b1;
    end
  end

endmodule

/* source/object_tracker.sv */
`timescale 1ns/10ps
`include "tracker_defines.svh"

module object_tracker import video_pkg::*, track_pkg::*; (
  input logic clk_pixel,
  input logic sys_rst,
  input rgb565_t pixel,
  input logic pixel_valid,
  input hcount_t hcount,
  input vcount_t vcount,
  input logic new_frame, // before the first pixel of a frame
  input channel_sel_e channel_sel,
  input color_t lower_bound,
  input color_t upper_bound,
  output hcount_t box_x_min,
  output hcount_t box_x_max,
  output vcount_t box_y_min,
  output vcount_t box_y_max,
  output logic box_found,
  output logic box_valid,
  output hcount_t com_x,
  output vcount_t com_y,
  output logic com_valid
);

  color_t red, green, blue, y, cr, cb;
  logic conv_valid;
  logic player_mask, saber_mask;

  // coordinates and strobe held back to line up with the masks
  hcount_t hcount_pipe [`MASK_LATENCY];
  vcount_t vcount_pipe [`MASK_LATENCY];
  logic [`MASK_LATENCY-1:0] new_frame_pipe;

  always_ff @(posedge clk_pixel) begin
    hcount_pipe[0] <= hcount;
    vcount_pipe[0] <= vcount;
    for (int i = 1; i < `MASK_LATENCY; i++) begin
      hcount_pipe[i] <= hcount_pipe[i-1];
      vcount_pipe[i] <= vcount_pipe[i-1];
    end
  end

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      new_frame_pipe <= '0; // no stray strobe out of reset
    end else begin
      new_frame_pipe <= {new_frame_pipe[`MASK_LATENCY-2:0], new_frame};
    end
  end

  color_convert color_convert_i (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst),
    .pixel(pixel), .pixel_valid(pixel_valid),
    .red(red), .green(green), .blue(blue),
    .y(y), .cr(cr), .cb(cb),
    .conv_valid(conv_valid)
  );

  channel_mask channel_mask_i (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst),
    .red(red), .green(green), .blue(blue),
    .y(y), .cr(cr), .cb(cb),
    .conv_valid(conv_valid), .channel_sel(channel_sel),
    .lower_bound(lower_bound), .upper_bound(upper_bound),
    .player_mask(player_mask), .saber_mask(saber_mask)
  );

  bounding_box bounding_box_i (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst),
    .hcount(hcount_pipe[`MASK_LATENCY-1]), .vcount(vcount_pipe[`MASK_LATENCY-1]),
    .frame_start(new_frame_pipe[`MASK_LATENCY-1]), .player_mask(player_mask),
    .box_x_min(box_x_min), .box_x_max(box_x_max),
    .box_y_min(box_y_min), .box_y_max(box_y_max),
    .box_found(box_found), .box_valid(box_valid)
  );

  center_of_mass center_of_mass_i (
    .clk_pixel(clk_pixel), .sys_rst(sys_rst),
    .hcount(hcount_pipe[`MASK_LATENCY-1]), .vcount(vcount_pipe[`MASK_LATENCY-1]),
    .frame_start(new_frame_pipe[`MASK_LATENCY-1]), .saber_mask(saber_mask),
    .com_x(com_x), .com_y(com_y), .com_valid(com_valid)
  );

endmodule

/* tb/object_tracker_assert.sv */
`timescale 1ns/10ps

module object_tracker_assert import track_pkg::*; (
  input logic clk_pixel,
  input logic sys_rst,
  input logic box_valid,
  input logic box_found,
  input hcount_t box_x_min,
  input hcount_t box_x_max,
  input logic com_valid
);

  // result strobes last exactly one cycle
  box_pulse: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    box_valid |=> !box_valid) else $error("box_valid high for more than one cycle");

  com_pulse: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    com_valid |=> !com_valid) else $error("com_valid high for more than one cycle");

  // a reset edge leaves both strobes low
  quiet_reset: assert property (@(posedge clk_pixel)
    sys_rst |=> !box_valid && !com_valid) else $error("result strobe during reset");

  box_order: assert property (@(posedge clk_pixel) disable iff (sys_rst)
    box_valid && box_found |-> box_x_min <= box_x_max) else $error("box x_min above x_max");

endmodule

bind object_tracker object_tracker_assert object_tracker_assert_i (
  .clk_pixel(clk_pixel),
  .sys_rst(sys_rst),
  .box_valid(box_valid),
  .box_found(box_found),
  .box_x_min(box_x_min),
  .box_x_max(box_x_max),
  .com_valid(com_valid)
);

/* tb/object_tracker_tb.sv */
`timescale 1ns/10ps
`include "tracker_defines.svh"

module object_tracker_tb import video_pkg::*, track_pkg::*; ();

  localparam int FRAME_W = 24;
  localparam int FRAME_H = 12;
  localparam int IDLE_CYCLES = 40; // idle gap that drains the pipe after each frame
  localparam int MAX_CYCLES = 20 * 360 + 1000; // 20 frames of ~330 cycles plus reset and tail
  localparam channel_sel_e CHANNELS [6] = '{CH_GREEN, CH_RED, CH_BLUE, CH_Y, CH_CR, CH_CB};
  localparam logic [4:0] RED_PICKS [4] = '{5'd7, 5'd8, 5'd16, 5'd17}; // 8 and 16 sit on the bounds

  typedef struct packed {
    logic found;
    hcount_t x_min;
    hcount_t x_max;
    vcount_t y_min;
    vcount_t y_max;
  } box_t;

  typedef struct packed {
    hcount_t x;
    vcount_t y;
  } com_t;

  logic clk_pixel, sys_rst;
  rgb565_t pixel;
  logic pixel_valid, new_frame;
  hcount_t hcount;
  vcount_t vcount;
  channel_sel_e channel_sel;
  color_t lower_bound, upper_bound;
  hcount_t box_x_min, box_x_max, com_x;
  vcount_t box_y_min, box_y_max, com_y;
  logic box_found, box_valid, com_valid;

  int seed = 32'h18f8_1591;
  int cycles = 0;
  box_t box_q [$]; // expected results in arrival order
  com_t com_q [$];
  box_t held_box = '0; // box outputs hold through empty frames
  logic ref_found = 1'b0;
  int ref_x_min, ref_x_max, ref_y_min, ref_y_max;
  int ref_sum_x = 0, ref_sum_y = 0, ref_count = 0;

  object_tracker object_tracker_i (.*);

  initial begin
    clk_pixel = 1'b0;
    forever #20 clk_pixel = ~clk_pixel; // 25 MHz pixel clock
  end

  // expansion and integer ycrcb straight from the formulas
  function automatic color_t ref_select(rgb565_t p, channel_sel_e sel);
    int r, g, b;
    r = {p[15:11], 3'b000};
    g = {p[10:5], 2'b00};
    b = {p[4:0], 3'b000};
    case (sel)
      CH_GREEN: return color_t'(g);
      CH_RED: return color_t'(r);
      CH_BLUE: return color_t'(b);
      CH_Y: return color_t'(((66 * r + 129 * g + 25 * b + 128) >>> 8) + 16);
      CH_CR: return color_t'(((112 * r - 94 * g - 18 * b + 128) >>> 8) + 128);
      CH_CB: return color_t'(((-38 * r - 74 * g + 112 * b + 128) >>> 8) + 128);
      default: return '0; // unused opcodes
    endcase
  endfunction

  function automatic logic ref_saber(rgb565_t p);
    color_t cbv;
    cbv = ref_select(p, CH_CB);
    return (cbv >= `SABER_CB_LO) && (cbv <= `SABER_CB_HI);
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_box(input logic exp_found, input hcount_t exp_x_min,
      input hcount_t exp_x_max, input vcount_t exp_y_min, input vcount_t exp_y_max);
    if (box_found !== exp_found || box_x_min !== exp_x_min || box_x_max !== exp_x_max ||
        box_y_min !== exp_y_min || box_y_max !== exp_y_max)
      fail_run({$sformatf("ERROR at %0t: box %0b x %0d..%0d y %0d..%0d", $time,
          box_found, box_x_min, box_x_max, box_y_min, box_y_max),
        $sformatf(", expected %0b x %0d..%0d y %0d..%0d",
          exp_found, exp_x_min, exp_x_max, exp_y_min, exp_y_max)});
  endtask

  task automatic check_com(input hcount_t exp_x, input vcount_t exp_y);
    if (com_x !== exp_x || com_y !== exp_y)
      fail_run($sformatf("ERROR at %0t: center (%0d,%0d), expected (%0d,%0d)",
        $time, com_x, com_y, exp_x, exp_y));
  endtask

  task automatic next_cycle();
    @(posedge clk_pixel);
    #2; // inputs move just after the edge
  endtask

  // queue what the finished frame should report at its boundary
  task automatic publish_frame();
    box_t b;
    com_t c;
    b = held_box;
    b.found = ref_found;
    if (ref_found) begin
      b.x_min = hcount_t'(ref_x_min);
      b.x_max = hcount_t'(ref_x_max);
      b.y_min = vcount_t'(ref_y_min);
      b.y_max = vcount_t'(ref_y_max);
      held_box = b;
    end
    box_q.push_back(b);
    if (ref_count != 0) begin // an empty frame gives no center pulse
      c.x = hcount_t'(ref_sum_x / ref_count);
      c.y = vcount_t'(ref_sum_y / ref_count);
      com_q.push_back(c);
    end
    ref_found = 1'b0;
    ref_count = 0;
    ref_sum_x = 0;
    ref_sum_y = 0;
  endtask

  task automatic strobe_frame();
    new_frame = 1'b1;
    pixel_valid = 1'b0;
    publish_frame();
    next_cycle();
    new_frame = 1'b0;
  endtask

  task automatic drive_pixel(input rgb565_t p, input logic v, input int x, input int yy);
    color_t sel_val;
    sel_val = ref_select(p, channel_sel);
    pixel = p;
    pixel_valid = v;
    hcount = hcount_t'(x);
    vcount = vcount_t'(yy);
    if (v && sel_val >= lower_bound && sel_val <= upper_bound) begin
      if (!ref_found || x < ref_x_min) ref_x_min = x;
      if (!ref_found || x > ref_x_max) ref_x_max = x;
      if (!ref_found || yy < ref_y_min) ref_y_min = yy;
      if (!ref_found || yy > ref_y_max) ref_y_max = yy;
      ref_found = 1'b1;
    end
    if (v && ref_saber(p)) begin
      ref_sum_x += x;
      ref_sum_y += yy;
      ref_count++;
    end
    next_cycle();
  endtask

  // mode 0 random, 1 some yellow, 2 black, 3 yellow but invalid, 4 red near the bounds
  task automatic run_frame(input channel_sel_e sel, input color_t lo, input color_t hi,
      input int mode);
    rgb565_t p;
    logic v;
    channel_sel = sel;
    lower_bound = lo;
    upper_bound = hi;
    strobe_frame();
    for (int yy = 0; yy < FRAME_H; yy++) begin
      for (int x = 0; x < FRAME_W; x++) begin
        p = $random(seed);
        v = 1'b1;
        case (mode)
          0: v = ($random(seed) & 7) != 0; // mostly valid
          1: if (($random(seed) & 3) == 0) p = 16'hFFE0; // cb of yellow is inside the window
          2: p = '0;
          3: begin
            p = 16'hFFE0;
            v = 1'b0;
          end
          4: p[15:11] = RED_PICKS[$unsigned($random(seed)) % 4];
          default: ;
        endcase
        drive_pixel(p, v, x, yy);
      end
    end
    pixel_valid = 1'b0;
    repeat (IDLE_CYCLES) next_cycle();
  endtask

  // one queue entry checked per result pulse
  initial begin
    box_t exp_box;
    com_t exp_com;
    forever begin
      @(negedge clk_pixel);
      if (box_valid) begin
        if (box_q.size() == 0)
          fail_run($sformatf("ERROR at %0t: box_valid with no frame pending", $time));
        exp_box = box_q.pop_front();
        check_box(exp_box.found, exp_box.x_min, exp_box.x_max, exp_box.y_min, exp_box.y_max);
      end
      if (com_valid) begin
        if (com_q.size() == 0)
          fail_run($sformatf("ERROR at %0t: com_valid with no center pending", $time));
        exp_com = com_q.pop_front();
        check_com(exp_com.x, exp_com.y);
      end
    end
  end

  always @(posedge clk_pixel) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES)
      fail_run($sformatf("timeout, the run did not finish within %0d cycles", MAX_CYCLES));
  end

  initial begin
    color_t a, b;
    sys_rst = 1'b1;
    pixel = '0;
    pixel_valid = 1'b0;
    new_frame = 1'b0;
    hcount = '0;
    vcount = '0;
    channel_sel = CH_GREEN;
    lower_bound = '0;
    upper_bound = '0;
    repeat (4) @(posedge clk_pixel);
    #2;
    sys_rst = 1'b0;
    check_box(1'b0, '0, '0, '0, '0); // everything zero out of reset
    check_com('0, '0);
    run_frame(CH_GREEN, 8'h00, 8'hFF, 0); // first strobe reports an empty box
    foreach (CHANNELS[i]) begin
      a = $random(seed);
      b = $random(seed);
      if (a > b) run_frame(CHANNELS[i], b, a, 0);
      else run_frame(CHANNELS[i], a, b, 0);
    end
    run_frame(CH_Y, 8'h20, 8'hC0, 1);
    run_frame(CH_GREEN, 8'd200, 8'd255, 2); // nothing masked
    run_frame(CH_GREEN, 8'h00, 8'hFF, 3);
    run_frame(CH_RED, 8'h40, 8'h80, 4);
    run_frame(CH_RED, 8'h80, 8'h80, 4); // single value window needs both ends inclusive
    strobe_frame(); // flush out the last frame
    while (box_q.size() != 0 || com_q.size() != 0) next_cycle();
    repeat (IDLE_CYCLES) next_cycle(); // a stray pulse would show here
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* files.f */
+incdir+source
source/video_pkg.sv
source/track_pkg.sv
source/color_convert.sv
source/channel_mask.sv
source/bounding_box.sv
source/center_of_mass.sv
source/object_tracker.sv
tb/object_tracker_assert.sv
tb/object_tracker_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module object_tracker_tb --Mdir obj_dir -o object_tracker_sim
	./obj_dir/object_tracker_sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
